// File: snn_settings.svh
// SNN tile sizing and tuning
`ifndef SNN_SETTINGS_SVH
`define SNN_SETTINGS_SVH

// ======================================================================
// Array geometry
// ======================================================================
`define SNN_NUM_INPUTS   8      // Presynaptic inputs per tile
`define SNN_NUM_NEURONS  4      // Neurons per tile
`define SNN_TS_WIDTH     16     // Timestep index width
`define SNN_WEIGHT_WIDTH 8      // Signed synaptic weight
`define SNN_VMEM_WIDTH   16     // Signed membrane potential

// ======================================================================
// Neuron dynamics and flow control
// ======================================================================
`define SNN_THRESHOLD    64     // Fire at or above this potential
`define SNN_LEAK_SHIFT   3      // Leak removes v >>> 3 each step
`define SNN_IN_DEPTH     4      // Input FIFO slots, sender credits
`define SNN_OUT_DEPTH    4      // Output event FIFO slots
`define SNN_OUT_CREDITS  2      // Receiver buffer credits at reset

`endif

// File: snn_pkg.sv
// SNN tile shared types
`include "snn_settings.svh"

package snn_pkg;

    // One bit per presynaptic input
    typedef logic [`SNN_NUM_INPUTS-1:0] in_spikes_t;

    // One bit per neuron, set when it fired
    typedef logic [`SNN_NUM_NEURONS-1:0] out_spikes_t;

    typedef logic signed [`SNN_WEIGHT_WIDTH-1:0] weight_t;  // Synaptic weight
    typedef logic signed [`SNN_VMEM_WIDTH-1:0]   vmem_t;    // Potential or current

    // Output event, one per timestep
    typedef struct packed {
        logic [`SNN_TS_WIDTH-1:0] timestep;   // Step that produced it
        out_spikes_t              spikes;     // Fired vector
    } spike_event_t;

endpackage

// File: credit_fifo.sv
// Credit receiver FIFO
module credit_fifo #(
    parameter type payload_t = logic,
    parameter int  DEPTH     = 4
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       push,
    input  payload_t                   push_data,
    input  logic                       pop,
    output payload_t                   pop_data,
    output logic                       empty,
    output logic [$clog2(DEPTH+1)-1:0] count
);

    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    payload_t          mem [DEPTH];     // Storage, no reset needed
    logic     [AW-1:0] wr_ptr;
    logic     [AW-1:0] rd_ptr;
    logic              do_push;
    logic              do_pop;

    // Guard anyway, sender credits should keep us off full
    assign do_push  = push && (count != DEPTH[$clog2(DEPTH+1)-1:0]);
    assign do_pop   = pop && !empty;
    assign empty    = (count == '0);
    assign pop_data = mem[rd_ptr];      // Head visible without a pop

    always_ff @(posedge clk) begin
        if (do_push) mem[wr_ptr] <= push_data;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (do_pop)  rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;     // Idle or push and pop together
            endcase
        end
    end

endmodule

// File: timestep_ctrl.sv
// Global timestep sequencer
`include "snn_settings.svh"

module timestep_ctrl (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic [`SNN_TS_WIDTH-1:0] num_timesteps,  // Held stable during a run
    input  logic                     start,
    input  logic                     tile_done,
    output logic [`SNN_TS_WIDTH-1:0] timestep_idx,
    output logic                     tile_start,
    output logic                     timestep_end,
    output logic                     sim_active,
    output logic                     sim_done
);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_START_TILE,
        ST_WAIT_TILE,
        ST_TIMESTEP_END,
        ST_NEXT,
        ST_DONE
    } state_t;

    state_t state;
    state_t next_state;
    logic   last_step;
    logic   go;

    assign go        = start && (num_timesteps != '0);   // Zero length run ignored
    assign last_step = (timestep_idx >= num_timesteps - 1'b1);

    // ==================================================================
    // Next state
    // ==================================================================
    always_comb begin
        next_state = state;
        case (state)
            ST_IDLE:         if (go) next_state = ST_START_TILE;
            ST_START_TILE:   next_state = ST_WAIT_TILE;
            ST_WAIT_TILE:    if (tile_done) next_state = ST_TIMESTEP_END;
            ST_TIMESTEP_END: next_state = ST_NEXT;
            ST_NEXT:         next_state = last_step ? ST_DONE : ST_START_TILE;
            ST_DONE:         if (start) next_state = ST_IDLE;   // Back to idle only
            default:         next_state = ST_IDLE;
        endcase
    end

    // ==================================================================
    // State and registered outputs
    // ==================================================================
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state        <= ST_IDLE;
            timestep_idx <= '0;
            tile_start   <= 1'b0;
            timestep_end <= 1'b0;
            sim_active   <= 1'b0;
            sim_done     <= 1'b0;
        end else begin
            state        <= next_state;
            tile_start   <= (state == ST_START_TILE);     // One cycle pulses
            timestep_end <= (state == ST_TIMESTEP_END);
            case (state)
                ST_IDLE: begin
                    sim_done <= 1'b0;
                    if (go) begin
                        timestep_idx <= '0;                // Fresh run from step 0
                        sim_active   <= 1'b1;
                    end
                end
                ST_NEXT: if (!last_step) timestep_idx <= timestep_idx + 1'b1;
                ST_DONE: begin
                    sim_active <= 1'b0;
                    sim_done   <= 1'b1;                    // Sticky until start
                end
                default: ;
            endcase
        end
    end

endmodule

// File: tile_accum.sv
// Spike driven current accumulator
`include "snn_settings.svh"

module tile_accum (
    input  logic                                      clk,
    input  logic                                      rst_n,
    input  logic                                      tile_start,
    input  logic                                      wr_en,
    input  logic [$clog2(`SNN_NUM_INPUTS*`SNN_NUM_NEURONS)-1:0] wr_addr,
    input  snn_pkg::weight_t                          wr_data,
    input  logic                                      in_empty,
    input  snn_pkg::in_spikes_t                       in_data,
    input  logic [$clog2(`SNN_OUT_DEPTH+1)-1:0]       out_count,
    output logic                                      in_pop,
    output snn_pkg::vmem_t                            acc0,
    output snn_pkg::vmem_t                            acc1,
    output snn_pkg::vmem_t                            acc2,
    output snn_pkg::vmem_t                            acc3,
    output logic                                      tile_done
);

    localparam int NI = `SNN_NUM_INPUTS;
    localparam int NN = `SNN_NUM_NEURONS;
    localparam int BW = $clog2(NI);

    typedef enum logic [1:0] {
        A_IDLE,
        A_WAIT_IN,      // Wait for a spike vector
        A_SCAN,         // One input bit per cycle
        A_WAIT_OUT      // Hold until the event FIFO has room
    } acc_state_t;

    acc_state_t          state;
    logic [BW-1:0]       bit_idx;
    snn_pkg::in_spikes_t vec_q;                  // Vector under scan
    snn_pkg::weight_t    weights [NI*NN];        // Row per input, column per neuron
    snn_pkg::vmem_t      acc_q   [NN];

    assign in_pop = (state == A_WAIT_IN) && !in_empty;   // Also the returned credit
    assign acc0   = acc_q[0];
    assign acc1   = acc_q[1];
    assign acc2   = acc_q[2];
    assign acc3   = acc_q[3];

    // Host weight port and datapath
    always_ff @(posedge clk) begin
        if (wr_en) weights[wr_addr] <= wr_data;
        if (in_pop) vec_q <= in_data;
        if (tile_start) begin
            for (int n = 0; n < NN; n++) acc_q[n] <= '0;
        end else if (state == A_SCAN && vec_q[bit_idx]) begin
            for (int n = 0; n < NN; n++) begin
                acc_q[n] <= acc_q[n] + snn_pkg::vmem_t'(weights[bit_idx*NN + n]);  // Sign extend
            end
        end
    end

    // ==================================================================
    // Sequencing
    // ==================================================================
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= A_IDLE;
            bit_idx   <= '0;
            tile_done <= 1'b0;
        end else begin
            tile_done <= 1'b0;
            case (state)
                A_IDLE: if (tile_start) state <= A_WAIT_IN;
                A_WAIT_IN: begin
                    bit_idx <= '0;
                    if (!in_empty) state <= A_SCAN;
                end
                A_SCAN: begin
                    bit_idx <= bit_idx + 1'b1;
                    if (bit_idx == BW'(NI - 1)) state <= A_WAIT_OUT;   // Last input
                end
                A_WAIT_OUT: begin
                    if (out_count < `SNN_OUT_DEPTH) begin    // Back-pressure stalls here
                        tile_done <= 1'b1;
                        state     <= A_IDLE;
                    end
                end
                default: state <= A_IDLE;
            endcase
        end
    end

endmodule

// File: lif_array.sv
// Leaky integrate and fire neurons
`include "snn_settings.svh"

module lif_array (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     tile_start,
    input  logic                     timestep_end,
    input  logic [`SNN_TS_WIDTH-1:0] timestep_idx,
    input  snn_pkg::vmem_t           acc0,
    input  snn_pkg::vmem_t           acc1,
    input  snn_pkg::vmem_t           acc2,
    input  snn_pkg::vmem_t           acc3,
    output logic                     ev_push,
    output snn_pkg::spike_event_t    ev_data
);

    localparam int NN = `SNN_NUM_NEURONS;

    snn_pkg::vmem_t       v_q     [NN];   // Membrane potentials
    snn_pkg::vmem_t       cur     [NN];
    snn_pkg::vmem_t       clamped [NN];
    snn_pkg::out_spikes_t fire;

    assign cur[0] = acc0;
    assign cur[1] = acc1;
    assign cur[2] = acc2;
    assign cur[3] = acc3;

    // Leak, integrate, clamp, then threshold test
    always_comb begin
        for (int n = 0; n < NN; n++) begin
            clamped[n] = v_q[n] - (v_q[n] >>> `SNN_LEAK_SHIFT) + cur[n];
            if (clamped[n] < 0) clamped[n] = '0;         // No negative potential
            fire[n] = (clamped[n] >= `SNN_THRESHOLD);
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ev_push <= 1'b0;
            for (int n = 0; n < NN; n++) v_q[n] <= '0;
        end else begin
            ev_push <= timestep_end;                     // One event per step
            if (tile_start && timestep_idx == '0) begin
                for (int n = 0; n < NN; n++) v_q[n] <= '0;   // New run
            end else if (timestep_end) begin
                for (int n = 0; n < NN; n++) v_q[n] <= fire[n] ? '0 : clamped[n];
            end
        end
    end

    // Event payload
    always_ff @(posedge clk) begin
        if (timestep_end) begin
            ev_data.timestep <= timestep_idx;
            ev_data.spikes   <= fire;
        end
    end

endmodule

// File: spike_tx.sv
// Credit based event transmitter
`include "snn_settings.svh"

module spike_tx (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     fifo_empty,
    input  snn_pkg::spike_event_t    fifo_data,
    input  logic                     out_credit,     // One credit back per pulse
    output logic                     fifo_pop,
    output logic                     out_valid,
    output logic [`SNN_TS_WIDTH-1:0] out_timestep,
    output snn_pkg::out_spikes_t     out_spikes
);

    localparam int CW = $clog2(`SNN_OUT_CREDITS + 1);

    logic [CW-1:0] credits;

    assign fifo_pop = !fifo_empty && (credits != '0);   // Send when both available

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            credits   <= CW'(`SNN_OUT_CREDITS);
            out_valid <= 1'b0;
        end else begin
            out_valid <= fifo_pop;
            case ({fifo_pop, out_credit})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;            // Send and return cancel
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (fifo_pop) begin
            out_timestep <= fifo_data.timestep;
            out_spikes   <= fifo_data.spikes;
        end
    end

endmodule

// File: snn_top.sv
// SNN accelerator tile top
`include "snn_settings.svh"

module snn_top (
    input  logic                                      clk,
    input  logic                                      rst_n,
    input  logic [`SNN_TS_WIDTH-1:0]                  num_timesteps,
    input  logic                                      start,
    input  logic                                      wr_en,
    input  logic [$clog2(`SNN_NUM_INPUTS*`SNN_NUM_NEURONS)-1:0] wr_addr,
    input  snn_pkg::weight_t                          wr_data,
    input  logic                                      in_valid,
    input  snn_pkg::in_spikes_t                       in_spikes,
    input  logic                                      out_credit,
    output logic                                      in_credit,
    output logic                                      out_valid,
    output logic [`SNN_TS_WIDTH-1:0]                  out_timestep,
    output snn_pkg::out_spikes_t                      out_spikes,
    output logic                                      sim_active,
    output logic                                      sim_done
);

    // ==================================================================
    // Internal nets
    // ==================================================================
    logic                                tile_start;
    logic                                timestep_end;
    logic                                tile_done;
    logic [`SNN_TS_WIDTH-1:0]            timestep_idx;
    logic                                in_pop;
    logic                                in_empty;
    snn_pkg::in_spikes_t                 in_data;
    snn_pkg::vmem_t                      acc0, acc1, acc2, acc3;
    logic                                ev_push;
    snn_pkg::spike_event_t               ev_data;
    logic                                ev_pop;
    logic                                ev_empty;
    snn_pkg::spike_event_t               ev_head;
    logic [$clog2(`SNN_OUT_DEPTH+1)-1:0] ev_count;

    assign in_credit = in_pop;      // Each pop frees one sender slot

    timestep_ctrl u_ctrl (
        .clk, .rst_n, .num_timesteps, .start, .tile_done,
        .timestep_idx, .tile_start, .timestep_end, .sim_active, .sim_done
    );

    // Input spike vectors
    credit_fifo #(.payload_t(snn_pkg::in_spikes_t), .DEPTH(`SNN_IN_DEPTH)) u_in_fifo (
        .clk, .rst_n, .push(in_valid), .push_data(in_spikes), .pop(in_pop),
        .pop_data(in_data), .empty(in_empty), .count()
    );

    tile_accum u_accum (
        .clk, .rst_n, .tile_start, .wr_en, .wr_addr, .wr_data,
        .in_empty, .in_data, .out_count(ev_count), .in_pop,
        .acc0, .acc1, .acc2, .acc3, .tile_done
    );

    lif_array u_lif (
        .clk, .rst_n, .tile_start, .timestep_end, .timestep_idx,
        .acc0, .acc1, .acc2, .acc3, .ev_push, .ev_data
    );

    // Output events
    credit_fifo #(.payload_t(snn_pkg::spike_event_t), .DEPTH(`SNN_OUT_DEPTH)) u_out_fifo (
        .clk, .rst_n, .push(ev_push), .push_data(ev_data), .pop(ev_pop),
        .pop_data(ev_head), .empty(ev_empty), .count(ev_count)
    );

    spike_tx u_tx (
        .clk, .rst_n, .fifo_empty(ev_empty), .fifo_data(ev_head), .out_credit,
        .fifo_pop(ev_pop), .out_valid, .out_timestep, .out_spikes
    );

endmodule

// File: tb_clock.sv
// Testbench clock source
module tb_clock #(
    parameter int PERIOD = 100
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;   // Free running
    end

endmodule

// File: snn_tb.sv
// SNN tile testbench
`include "snn_settings.svh"

module snn_tb;

    localparam int NI    = `SNN_NUM_INPUTS;
    localparam int NN    = `SNN_NUM_NEURONS;
    localparam int STEPS = 12;                   // Timesteps per run
    localparam int AW    = $clog2(NI * NN);
    localparam int LIMIT = 3000;                 // Cycles per wait

    logic                     clk;
    logic                     rst_n = 1'b0;
    logic [`SNN_TS_WIDTH-1:0] num_timesteps = '0;
    logic                     start = 1'b0;
    logic                     wr_en = 1'b0;
    logic [AW-1:0]            wr_addr = '0;
    snn_pkg::weight_t         wr_data = '0;
    logic                     in_valid = 1'b0;
    snn_pkg::in_spikes_t      in_spikes = '0;
    logic                     out_credit = 1'b0;
    logic                     in_credit;
    logic                     out_valid;
    logic [`SNN_TS_WIDTH-1:0] out_timestep;
    snn_pkg::out_spikes_t     out_spikes;
    logic                     sim_active;
    logic                     sim_done;

    int                    weight_ref [NI*NN];   // Host copy of the weights
    snn_pkg::in_spikes_t   vec_ref    [STEPS];   // Vectors for the current run
    snn_pkg::spike_event_t exp_q      [$];
    string                 test_name = "reset";
    int errors = 0;
    int checks = 0;
    int vec_sent = 0;         // Sender side
    int vec_target = 0;       // Total vectors allowed so far
    int in_returned = 0;      // in_credit pulses seen
    int ev_recv = 0;
    int cred_ret = 0;         // out_credit pulses given
    int hold_valids = 0;      // Events seen while credits held back
    int rx_delay = 0;
    bit hold_credit = 1'b0;

    tb_clock #(.PERIOD(100)) u_clk (.clk);

    snn_top uut (
        .clk, .rst_n, .num_timesteps, .start, .wr_en, .wr_addr, .wr_data,
        .in_valid, .in_spikes, .out_credit, .in_credit, .out_valid,
        .out_timestep, .out_spikes, .sim_active, .sim_done
    );

    // ==================================================================
    // Reference model
    // ==================================================================
    function automatic void lif_reference();
        int v [NN];
        int cur;
        snn_pkg::spike_event_t ev;
        for (int n = 0; n < NN; n++) v[n] = 0;      // Fresh run
        for (int t = 0; t < STEPS; t++) begin
            ev.timestep = `SNN_TS_WIDTH'(t);
            for (int n = 0; n < NN; n++) begin
                cur = 0;
                for (int i = 0; i < NI; i++) begin
                    if (vec_ref[t][i]) cur += weight_ref[i*NN + n];
                end
                v[n] = v[n] - (v[n] >>> `SNN_LEAK_SHIFT) + cur;   // Leak then integrate
                if (v[n] < 0) v[n] = 0;
                ev.spikes[n] = (v[n] >= `SNN_THRESHOLD);
                if (ev.spikes[n]) v[n] = 0;                      // Reset on fire
            end
            exp_q.push_back(ev);
        end
    endfunction

    // Input sender, spends one credit per vector
    always @(posedge clk) begin
        if (rst_n && vec_sent < vec_target && vec_sent - in_returned < `SNN_IN_DEPTH
                && $urandom_range(3) != 0) begin
            in_valid  <= 1'b1;
            in_spikes <= vec_ref[vec_sent % STEPS];
            vec_sent  = vec_sent + 1;
        end else begin
            in_valid <= 1'b0;
        end
    end

    // Output receiver, gives credits back after a random delay
    always @(posedge clk) begin
        if (rx_delay > 0) begin
            rx_delay   = rx_delay - 1;
            out_credit <= 1'b0;
        end else if (rst_n && !hold_credit && ev_recv > cred_ret) begin
            out_credit <= 1'b1;
            cred_ret   = cred_ret + 1;
            rx_delay   = $urandom_range(3);
        end else begin
            out_credit <= 1'b0;
        end
    end

    // Input credit bookkeeping
    always @(negedge clk) begin
        if (rst_n) begin
            if (in_credit) in_returned++;
            checks++;
            assert (vec_sent >= in_returned && vec_sent - in_returned <= `SNN_IN_DEPTH) else begin
                errors++;
                $display("%s: sender outstanding vector count %0d is outside 0 to %0d",
                         test_name, vec_sent - in_returned, `SNN_IN_DEPTH);
            end
        end
    end

    // ==================================================================
    // Event compare
    // ==================================================================
    always @(negedge clk) begin : compare_events
        snn_pkg::spike_event_t exp_ev;
        if (rst_n && out_valid) begin
            ev_recv++;
            if (hold_credit) hold_valids++;
            checks++;
            assert (exp_q.size() > 0) else begin
                errors++;
                $display("%s: output event arrived when none was expected", test_name);
            end
            if (exp_q.size() > 0) begin
                exp_ev = exp_q.pop_front();
                assert (out_timestep == exp_ev.timestep) else begin
                    errors++;
                    $display("error %s timestep: expected %0d actual %0d",
                             test_name, exp_ev.timestep, out_timestep);
                end
                assert (out_spikes == exp_ev.spikes) else begin
                    errors++;
                    $display("error %s spikes at step %0d: expected %b actual %b",
                             test_name, exp_ev.timestep, exp_ev.spikes, out_spikes);
                end
            end
        end
    end

    task automatic abort_on_timeout(input string what);
        $display("%s: timed out waiting for %s", test_name, what);
        $display("checks %0d errors %0d", checks, errors + 1);
        $display("Checks failed");
        $finish;
    endtask

    task automatic pulse_start(input int steps);
        @(posedge clk);
        num_timesteps <= `SNN_TS_WIDTH'(steps);
        start         <= 1'b1;
        @(posedge clk);
        start         <= 1'b0;
    endtask

    // Weights only change while the controller is idle
    task automatic load_weights();
        for (int k = 0; k < NI*NN; k++) begin
            weight_ref[k] = int'($urandom_range(100)) - 40;
            @(posedge clk);
            wr_en   <= 1'b1;
            wr_addr <= AW'(k);
            wr_data <= snn_pkg::weight_t'(weight_ref[k]);
        end
        @(posedge clk);
        wr_en <= 1'b0;
    endtask

    task automatic run_case(input string name, input bit withhold);
        int t;
        int ev_base;
        test_name = name;
        ev_base   = ev_recv;
        load_weights();
        for (int s = 0; s < STEPS; s++) vec_ref[s] = snn_pkg::in_spikes_t'($urandom);
        lif_reference();
        hold_credit = withhold;
        vec_target  = vec_target + STEPS;
        pulse_start(STEPS);
        if (withhold) begin
            t = 0;
            while (ev_recv == ev_base && t < LIMIT) begin   // No credit is owed before this
                @(posedge clk);
                t++;
            end
            if (ev_recv == ev_base) abort_on_timeout("the first output event");
            repeat (40) @(posedge clk);              // Receiver buffer full window
            checks++;
            assert (hold_valids <= `SNN_OUT_CREDITS) else begin
                errors++;
                $display("error %s held credits: expected at most %0d actual %0d",
                         name, `SNN_OUT_CREDITS, hold_valids);
            end
            hold_credit = 1'b0;
        end
        t = 0;
        while (exp_q.size() > 0 && t < LIMIT) begin
            @(negedge clk);
            t++;
        end
        if (exp_q.size() > 0) abort_on_timeout("all output events");
        t = 0;
        while (!sim_done && t < LIMIT) begin
            @(negedge clk);
            t++;
        end
        if (!sim_done) abort_on_timeout("sim_done");
        checks += 3;
        assert (!sim_active) else begin
            errors++;
            $display("%s: sim_active still high after sim_done", name);
        end
        assert (ev_recv - ev_base == STEPS) else begin
            errors++;
            $display("error %s event count: expected %0d actual %0d",
                     name, STEPS, ev_recv - ev_base);
        end
        assert (in_returned == vec_target) else begin
            errors++;
            $display("error %s vectors consumed: expected %0d actual %0d",
                     name, vec_target, in_returned);
        end
    endtask

    // ==================================================================
    // Main sequence
    // ==================================================================
    initial begin
        int t;
        void'($urandom(32'h29d0f681));
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
        run_case("run1", 1'b1);
        test_name = "idle";
        pulse_start(0);                              // Done back to idle
        t = 0;
        while (sim_done && t < LIMIT) begin
            @(negedge clk);
            t++;
        end
        if (sim_done) abort_on_timeout("return to idle");
        pulse_start(0);                              // Zero length, ignored
        for (int c = 0; c < 10; c++) begin
            @(negedge clk);
            checks++;
            assert (!sim_active) else begin
                errors++;
                $display("idle: start with zero timesteps raised sim_active");
            end
        end
        run_case("run2", 1'b0);
        repeat (5) @(negedge clk);
        $display("checks %0d errors %0d", checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// File: project.f
+incdir+.
snn_pkg.sv
credit_fifo.sv
timestep_ctrl.sv
tile_accum.sv
lif_array.sv
spike_tx.sv
snn_top.sv
tb_clock.sv
snn_tb.sv

// File: Makefile
SRCS := $(filter %.sv,$(shell cat project.f))

obj_dir/Vsnn_tb: project.f snn_settings.svh $(SRCS)
	verilator --binary --assert -j 0 -f project.f --top-module snn_tb -o Vsnn_tb

run: obj_dir/Vsnn_tb
	@out="$$(./obj_dir/Vsnn_tb)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "All checks passed"

clean:
	rm -rf obj_dir

.PHONY: run clean
